// File: include/lb_defs.svh
// depth and widths of the load buffer
// LB_ADDR_HI/LB_ADDR_LO must span exactly LB_WADDR_W bits of the byte address
// a tag of zero is reserved to mean the operand is ready
`ifndef LB_DEFS_SVH
`define LB_DEFS_SVH

`define LB_DEPTH	6	// entries, the dispatcher starts with this many credits
`define LB_TAG_W	5	// rob tag width
`define LB_DATA_W	32	// data word
`define LB_IMM_W	16	// signed load offset

// word address sent to memory
`define LB_WADDR_W	23
`define LB_ADDR_HI	24
`define LB_ADDR_LO	2

`endif

// File: rtl/lb_pkg.sv
// types shared by the load buffer blocks and its testbench
// widths follow lb_defs.svh, tag value 0 means ready
`default_nettype none

`include "lb_defs.svh"

package lb_pkg;

	typedef logic [`LB_TAG_W-1:0]			lb_tag_t;	// rob tag
	typedef logic [`LB_DATA_W-1:0]		lb_word_t;	// data word
	typedef logic [$clog2(`LB_DEPTH)-1:0]	lb_idx_t;	// entry index

	// load from the dispatcher
	typedef struct packed {
		logic				valid;
		lb_tag_t			rob_tag;	// destination slot in the rob
		lb_word_t			base;		// base value, meaningful when base_tag is 0
		lb_tag_t			base_tag;	// producer of the base, 0 when ready
		logic [`LB_IMM_W-1:0]	imm;		// signed offset
	} lb_issue_t;

	// common data bus packet, both directions
	typedef struct packed {
		logic		valid;
		lb_tag_t	tag;
		lb_word_t	data;
	} cdb_t;

	// single word read request
	typedef struct packed {
		logic					valid;
		logic [`LB_WADDR_W-1:0]	waddr;
	} mem_req_t;

	typedef struct packed {
		logic		valid;
		lb_word_t	data;
	} mem_rsp_t;

	// controller states, one memory access in flight at most
	typedef enum logic [1:0] {
		st_idle,		// looking for a ready entry
		st_mem_wait,	// request sent, waiting on the response
		st_cdb_req		// result held until the cdb grant
	} lb_state_e;

endpackage

`default_nettype wire

// File: rtl/lb_entries.sv
// entry storage of the load buffer
// issue lands in the slot given by alloc_idx, which must be free
// a cdb broadcast in the issue cycle is caught by the incoming load as well
`default_nettype none

`include "lb_defs.svh"

module lb_entries (
	input  wire logic					clk,
	input  wire logic					arst_n,
	input  wire logic					flush,
	input  wire lb_pkg::lb_issue_t		issue,
	input  wire lb_pkg::lb_idx_t		alloc_idx,
	input  wire lb_pkg::cdb_t			cdb_in,
	input  wire logic					free_valid,
	input  wire lb_pkg::lb_idx_t		free_idx,
	input  wire lb_pkg::lb_idx_t		sel_idx,
	output logic [`LB_DEPTH-1:0]		ready_vec,
	output logic [`LB_DEPTH-1:0]		valid_vec,
	output lb_pkg::lb_word_t			sel_base,
	output logic [`LB_IMM_W-1:0]		sel_imm,
	output lb_pkg::lb_tag_t				sel_tag
);
	import lb_pkg::*;

	logic [`LB_DEPTH-1:0]	valid_q;
	lb_word_t				base_q [`LB_DEPTH];
	lb_tag_t				base_tag_q [`LB_DEPTH];
	logic [`LB_IMM_W-1:0]	imm_q [`LB_DEPTH];
	lb_tag_t				rob_tag_q [`LB_DEPTH];
	logic [`LB_DEPTH-1:0]	wake;
	logic					iss_wake;	// broadcast matches the load being issued

	// tag compare per entry, only pending bases listen
	always_comb
	begin
		for (int i = 0; i < `LB_DEPTH; i++)
			wake[i] = cdb_in.valid && valid_q[i] && (base_tag_q[i] != '0) &&
				(cdb_in.tag == base_tag_q[i]);
	end

	assign iss_wake = cdb_in.valid && (issue.base_tag != '0) && (cdb_in.tag == issue.base_tag);

	// occupancy, cleared by flush, no credit comes back for those
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			valid_q <= '0;
		else if (flush)
			valid_q <= '0;
		else
		begin
			if (issue.valid)
				valid_q[alloc_idx] <= 1'b1;
			if (free_valid)
				valid_q[free_idx] <= 1'b0;	// never the alloc slot, it was still valid
		end
	end

	// payload
	always_ff @(posedge clk)
	begin
		for (int i = 0; i < `LB_DEPTH; i++)
		begin
			if (issue.valid && (alloc_idx == lb_idx_t'(i)))
			begin
				rob_tag_q[i] <= issue.rob_tag;
				imm_q[i] <= issue.imm;
				base_q[i] <= iss_wake ? cdb_in.data : issue.base;
				base_tag_q[i] <= iss_wake ? '0 : issue.base_tag;
			end
			else if (wake[i])
			begin
				base_q[i] <= cdb_in.data;	// producer result replaces the base
				base_tag_q[i] <= '0;
			end
		end
	end

	always_comb
	begin
		for (int i = 0; i < `LB_DEPTH; i++)
			ready_vec[i] = valid_q[i] && (base_tag_q[i] == '0);
	end

	assign valid_vec = valid_q;
	assign sel_base = base_q[sel_idx];
	assign sel_imm = imm_q[sel_idx];
	assign sel_tag = rob_tag_q[sel_idx];

	// the dispatcher's credit count keeps issue off occupied slots
	a_issue_free: assert property (@(posedge clk) disable iff (!arst_n)
		issue.valid && !flush |-> !valid_q[alloc_idx]);

	// controller only frees the entry it is serving
	a_free_valid: assert property (@(posedge clk) disable iff (!arst_n)
		free_valid |-> valid_q[free_idx]);

endmodule

`default_nettype wire

// File: rtl/lb_agu.sv
// address unit, purely combinational
// byte address is base plus the sign-extended offset, wraps modulo 2^LB_DATA_W
`default_nettype none

`include "lb_defs.svh"

module lb_agu (
	input  wire lb_pkg::lb_word_t			base,
	input  wire logic [`LB_IMM_W-1:0]		imm,
	output logic [`LB_WADDR_W-1:0]			waddr
);
	import lb_pkg::*;

	lb_word_t	imm_ext;	// offset widened to a full word
	lb_word_t	byte_addr;

	// replicate the offset sign into the upper bits
	assign imm_ext = {{(`LB_DATA_W-`LB_IMM_W){imm[`LB_IMM_W-1]}}, imm};

	assign byte_addr = base + imm_ext;

	// drop the byte offset and the unused high bits
	assign waddr = byte_addr[`LB_ADDR_HI:`LB_ADDR_LO];

endmodule

`default_nettype wire

// File: rtl/lb_ctrl.sv
// load buffer controller, one memory access in flight at a time
// after a flush during mem_wait the late response is dropped before a new request
// credit_ret pulses the cycle after each granted result
`default_nettype none

`include "lb_defs.svh"

module lb_ctrl (
	input  wire logic					clk,
	input  wire logic					arst_n,
	input  wire logic					flush,
	input  wire logic [`LB_DEPTH-1:0]	ready_vec,
	input  wire logic [`LB_DEPTH-1:0]	valid_vec,
	input  wire logic					issue_valid,
	input  wire logic					mem_rsp_valid,
	input  wire logic					cdb_grant,
	input  wire logic [`LB_WADDR_W-1:0]	waddr,
	output lb_pkg::lb_idx_t				alloc_idx,
	output lb_pkg::lb_idx_t				sel_idx,
	output lb_pkg::mem_req_t			mem_req,
	output logic						capture,
	output logic						cdb_req,
	output logic						free_valid,
	output lb_pkg::lb_idx_t				free_idx,
	output logic						credit_ret
);
	import lb_pkg::*;

	lb_state_e				state_q;
	lb_idx_t				cur_q;		// entry being served
	lb_idx_t				last_q;		// round-robin origin
	lb_idx_t				pick_idx;
	logic					pick_found;
	logic					drop_q;		// stale response still due from memory
	logic					req_valid_q;
	logic [`LB_WADDR_W-1:0]	req_waddr_q;	// payload, no reset
	logic					credit_q;

	// lowest free slot, scanned downward so the lowest one wins
	always_comb
	begin
		alloc_idx = '0;
		for (int i = `LB_DEPTH-1; i >= 0; i--)
			if (!valid_vec[i])
				alloc_idx = lb_idx_t'(i);
	end

	// first ready entry after the last one served
	always_comb
	begin
		int pos;
		pick_found = 1'b0;
		pick_idx = last_q;
		for (int k = 1; k <= `LB_DEPTH; k++)
		begin
			pos = int'(last_q) + k;
			if (pos >= `LB_DEPTH)
				pos = pos - `LB_DEPTH;	// wrap
			if (!pick_found && ready_vec[pos])
			begin
				pick_found = 1'b1;
				pick_idx = lb_idx_t'(pos);
			end
		end
	end

	assign sel_idx = (state_q == st_idle) ? pick_idx : cur_q;	// agu follows the pick in idle
	assign capture = (state_q == st_mem_wait) && mem_rsp_valid && !flush;
	assign cdb_req = (state_q == st_cdb_req);
	assign free_valid = cdb_req && cdb_grant && !flush;
	assign free_idx = cur_q;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state_q <= st_idle;
			cur_q <= '0;
			last_q <= lb_idx_t'(`LB_DEPTH-1);	// first search starts at entry 0
			drop_q <= 1'b0;
			req_valid_q <= 1'b0;
			credit_q <= 1'b0;
		end
		else
		begin
			req_valid_q <= 1'b0;	// single-cycle request
			credit_q <= free_valid;
			drop_q <= (drop_q || ((state_q == st_mem_wait) && flush)) && !mem_rsp_valid;
			if (flush)
				state_q <= st_idle;
			else
			begin
				case (state_q)
					st_idle:
						if (pick_found && !drop_q)
						begin
							state_q <= st_mem_wait;
							cur_q <= pick_idx;
							last_q <= pick_idx;
							req_valid_q <= 1'b1;
						end
					st_mem_wait:
						if (mem_rsp_valid)
							state_q <= st_cdb_req;
					st_cdb_req:
						if (cdb_grant)
							state_q <= st_idle;	// entry freed on this edge
					default:
						state_q <= st_idle;
				endcase
			end
		end
	end

	// address of the picked entry, captured with the request
	always_ff @(posedge clk)
	begin
		if (state_q == st_idle)
			req_waddr_q <= waddr;
	end

	assign mem_req = '{valid: req_valid_q, waddr: req_waddr_q};
	assign credit_ret = credit_q;

	a_grant_req: assert property (@(posedge clk) disable iff (!arst_n)
		cdb_grant |-> cdb_req);

	// responses come only for the access in flight, or the one a flush orphaned
	a_rsp_wait: assert property (@(posedge clk) disable iff (!arst_n)
		mem_rsp_valid |-> (state_q == st_mem_wait) || drop_q);

	// dispatcher holds no credit while every slot is taken
	a_issue_credit: assert property (@(posedge clk) disable iff (!arst_n)
		issue_valid && !flush |-> !(&valid_vec));

endmodule

`default_nettype wire

// File: rtl/lb_result.sv
// result holding register toward the cdb
// data and tag are captured in the response cycle and held until cdb_req drops
`default_nettype none

`include "lb_defs.svh"

module lb_result (
	input  wire logic				clk,
	input  wire logic				arst_n,
	input  wire logic				flush,
	input  wire logic				capture,
	input  wire lb_pkg::mem_rsp_t	rsp,
	input  wire lb_pkg::lb_tag_t	tag,
	input  wire logic				cdb_req,
	output lb_pkg::cdb_t			cdb_out
);
	import lb_pkg::*;

	logic		hold_q;		// a captured word is waiting for its grant
	lb_word_t	data_q;
	lb_tag_t	tag_q;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			hold_q <= 1'b0;
		else if (flush)
			hold_q <= 1'b0;
		else if (capture)
			hold_q <= 1'b1;
		else if (!cdb_req)
			hold_q <= 1'b0;	// granted and released
	end

	// payload, stable for the whole request
	always_ff @(posedge clk)
	begin
		if (capture)
		begin
			data_q <= rsp.data;
			tag_q <= tag;	// rob tag of the served entry
		end
	end

	assign cdb_out = '{valid: hold_q && cdb_req, tag: tag_q, data: data_q};

endmodule

`default_nettype wire

// File: rtl/load_buffer.sv
// load buffer top, LB_DEPTH entries with credit flow control on issue
// the dispatcher starts with LB_DEPTH credits after reset or flush
// result is held on cdb_out while cdb_req waits for cdb_grant
`default_nettype none

`include "lb_defs.svh"

module load_buffer (
	input  wire logic				clk,
	input  wire logic				arst_n,
	input  wire logic				flush,
	input  wire lb_pkg::lb_issue_t	issue,
	input  wire lb_pkg::cdb_t		cdb_in,
	input  wire lb_pkg::mem_rsp_t	mem_rsp,
	input  wire logic				cdb_grant,
	output logic					credit_ret,
	output lb_pkg::mem_req_t		mem_req,
	output lb_pkg::cdb_t			cdb_out,
	output logic					cdb_req
);
	import lb_pkg::*;

	lb_idx_t				alloc_idx;
	lb_idx_t				sel_idx;
	lb_idx_t				free_idx;
	logic					free_valid;
	logic					capture;
	logic [`LB_DEPTH-1:0]	ready_vec;
	logic [`LB_DEPTH-1:0]	valid_vec;
	lb_word_t				sel_base;
	logic [`LB_IMM_W-1:0]	sel_imm;
	lb_tag_t				sel_tag;	// rob tag of the selected entry
	logic [`LB_WADDR_W-1:0]	waddr;

	lb_ctrl u_ctrl (
		.clk			(clk),
		.arst_n			(arst_n),
		.flush			(flush),
		.ready_vec		(ready_vec),
		.valid_vec		(valid_vec),
		.issue_valid	(issue.valid),
		.mem_rsp_valid	(mem_rsp.valid),
		.cdb_grant		(cdb_grant),
		.waddr			(waddr),
		.alloc_idx		(alloc_idx),
		.sel_idx		(sel_idx),
		.mem_req		(mem_req),
		.capture		(capture),
		.cdb_req		(cdb_req),
		.free_valid		(free_valid),
		.free_idx		(free_idx),
		.credit_ret		(credit_ret)
	);

	lb_entries u_entries (
		.clk		(clk),
		.arst_n		(arst_n),
		.flush		(flush),
		.issue		(issue),
		.alloc_idx	(alloc_idx),
		.cdb_in		(cdb_in),
		.free_valid	(free_valid),
		.free_idx	(free_idx),
		.sel_idx	(sel_idx),
		.ready_vec	(ready_vec),
		.valid_vec	(valid_vec),
		.sel_base	(sel_base),
		.sel_imm	(sel_imm),
		.sel_tag	(sel_tag)
	);

	// address of whichever entry the controller points at
	lb_agu u_agu (
		.base	(sel_base),
		.imm	(sel_imm),
		.waddr	(waddr)
	);

	lb_result u_result (
		.clk		(clk),
		.arst_n		(arst_n),
		.flush		(flush),
		.capture	(capture),
		.rsp		(mem_rsp),
		.tag		(sel_tag),
		.cdb_req	(cdb_req),
		.cdb_out	(cdb_out)
	);

endmodule

`default_nettype wire

// File: sim/tb_load_buffer.sv
// testbench for load_buffer, memory answers 1 to 4 cycles after each request
// memory data is the word address xor 32'h5a5a0000, rob tags in the table must be unique
// the dispatcher credit count lives here and restarts at LB_DEPTH on reset or flush
`default_nettype none

`include "lb_defs.svh"

module tb_load_buffer;
	import lb_pkg::*;

	localparam int NROWS = 15;
	localparam int NTAGS = 1 << `LB_TAG_W;
	localparam int WDOG_CYCLES = NROWS * 16 + 200;
	localparam logic [1:0] CTL_NONE = 2'd0;		// plain issue
	localparam logic [1:0] CTL_DRAIN = 2'd1;	// wait for all results before this issue
	localparam logic [1:0] CTL_FLUSH = 2'd2;	// flush two cycles after this issue
	localparam logic [3:0] NO_WAKE = 4'hf;

	// one load of the stimulus table
	typedef struct packed {
		lb_tag_t				rob_tag;
		lb_word_t				base;
		lb_tag_t				base_tag;	// 0 when the base is ready
		logic [`LB_IMM_W-1:0]	imm;
		lb_word_t				wake;		// broadcast value for base_tag
		logic [3:0]				wdly;		// issue to broadcast, 0 is the issue cycle
		logic [1:0]				ctl;
	} row_t;

	logic		clk;
	logic		arst_n;
	logic		flush;
	lb_issue_t	issue;
	cdb_t		cdb_in;
	mem_rsp_t	mem_rsp;
	logic		cdb_grant;
	logic		credit_ret;
	mem_req_t	mem_req;
	cdb_t		cdb_out;
	logic		cdb_req;

	row_t					rows [NROWS];
	logic					issued [NROWS];
	logic					fired [NROWS];
	int						wake_due [NROWS];
	logic					pend [NTAGS];		// result still expected
	logic					woke [NTAGS];		// base known to the buffer
	logic					done [NTAGS];
	logic					killed [NTAGS];		// dropped by a flush
	logic [`LB_WADDR_W-1:0]	exp_waddr [NTAGS];
	integer					seed = 32'hc8355a84;
	int						errors = 0;
	int						credits = `LB_DEPTH;
	int						ret_cnt = 0;
	int						done_cnt = 0;
	int						n_pend = 0;
	int						cyc = 0;
	logic					arst_q = 1'b0;
	logic					flush_q = 1'b0;
	logic					stall_q = 1'b0;		// cdb_req held without grant last edge
	cdb_t					out_q;

	load_buffer dut (
		.clk		(clk),
		.arst_n		(arst_n),
		.flush		(flush),
		.issue		(issue),
		.cdb_in		(cdb_in),
		.mem_rsp	(mem_rsp),
		.cdb_grant	(cdb_grant),
		.credit_ret	(credit_ret),
		.mem_req	(mem_req),
		.cdb_out	(cdb_out),
		.cdb_req	(cdb_req)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// byte address = base + signed offset, memory sees bits 24..2
	function automatic logic [`LB_WADDR_W-1:0] word_addr(lb_word_t base,
		logic [`LB_IMM_W-1:0] imm);
		lb_word_t	a;
		a = base + 32'($signed(imm));
		return a[`LB_ADDR_HI:`LB_ADDR_LO];
	endfunction

	function automatic lb_word_t mem_word(logic [`LB_WADDR_W-1:0] waddr);
		return lb_word_t'(waddr) ^ 32'h5a5a_0000;
	endfunction

	task automatic report_mismatch(string name, logic [63:0] got, logic [63:0] exp);
		errors++;
		$display("CHECK FAILED %s: got %h expected %h at %0t", name, got, exp, $time);
	endtask

	task automatic note_error(string msg);
		errors++;
		$display("error at %0t: %s", $time, msg);
	endtask

	task automatic fill_table();
		rows[0] = '{5'd1, 32'h0000_1000, 5'd0, 16'h0010, 32'h0, NO_WAKE, CTL_NONE};
		rows[1] = '{5'd2, 32'h0001_0000, 5'd0, 16'hfff0, 32'h0, NO_WAKE, CTL_NONE};	// negative
		rows[2] = '{5'd3, 32'hdead_beef, 5'd20, 16'h0004, 32'h0000_2000, 4'd0, CTL_NONE};
		rows[3] = '{5'd4, 32'hdead_beef, 5'd21, 16'h8000, 32'h0004_0000, 4'd6, CTL_NONE};
		rows[4] = '{5'd5, 32'h00ff_fffc, 5'd0, 16'h0008, 32'h0, NO_WAKE, CTL_NONE};	// bit 24
		rows[5] = '{5'd6, 32'hdead_beef, 5'd22, 16'h7ffc, 32'h1234_5678, 4'd3, CTL_NONE};
		rows[6] = '{5'd7, 32'h8000_0000, 5'd0, 16'hfffc, 32'h0, NO_WAKE, CTL_NONE};
		rows[7] = '{5'd8, 32'hdead_beef, 5'd23, 16'h0020, 32'h0000_0100, 4'd1, CTL_NONE};
		rows[8] = '{5'd9, 32'h0000_0040, 5'd0, 16'h0000, 32'h0, NO_WAKE, CTL_NONE};
		// flushed group, the first one is likely caught in mem_wait
		// tags 24 and 25 are broadcast only after the flush, cleared entries ignore them
		rows[9] = '{5'd10, 32'h0000_5000, 5'd0, 16'h0000, 32'h0, NO_WAKE, CTL_DRAIN};
		rows[10] = '{5'd11, 32'h0000_0000, 5'd24, 16'h0004, 32'h0000_6000, 4'd5, CTL_NONE};
		rows[11] = '{5'd12, 32'h0000_0000, 5'd25, 16'h0008, 32'h0000_7000, 4'd5, CTL_FLUSH};
		rows[12] = '{5'd13, 32'h0000_3000, 5'd0, 16'h0100, 32'h0, NO_WAKE, CTL_NONE};
		rows[13] = '{5'd14, 32'hffff_ffff, 5'd26, 16'hff00, 32'h0001_0000, 4'd2, CTL_NONE};
		rows[14] = '{5'd15, 32'h0000_0000, 5'd0, 16'hfffc, 32'h0, NO_WAKE, CTL_NONE};	// wraps
	endtask

	// at most one producer broadcast per cycle, later ones slip
	task automatic fire_wakes();
		for (int r = 0; r < NROWS; r++)
			if (issued[r] && !fired[r] && rows[r].wdly != NO_WAKE && cyc >= wake_due[r] &&
				!cdb_in.valid)
			begin
				cdb_in = '{valid: 1'b1, tag: rows[r].base_tag, data: rows[r].wake};
				woke[rows[r].rob_tag] = 1'b1;
				fired[r] = 1'b1;
			end
	endtask

	task automatic next_cycle();
		fire_wakes();
		@(negedge clk);
		issue = '0;
		cdb_in = '0;
		flush = 1'b0;
		cyc++;
	endtask

	task automatic issue_row(int r);
		row_t	w;
		w = rows[r];
		while (credits == 0)
			next_cycle();	// no credit, hold the load back
		issue = '{valid: 1'b1, rob_tag: w.rob_tag, base: w.base, base_tag: w.base_tag,
			imm: w.imm};
		issued[r] = 1'b1;
		wake_due[r] = cyc + int'(w.wdly);
		pend[w.rob_tag] = 1'b1;
		woke[w.rob_tag] = (w.base_tag == '0);
		exp_waddr[w.rob_tag] = word_addr((w.base_tag == '0) ? w.base : w.wake, w.imm);
		n_pend++;
		next_cycle();
	endtask

	task automatic expect_quiet();
		if (mem_req.valid !== 1'b0)
			report_mismatch("mem_req.valid", mem_req.valid, 0);
		if (cdb_req !== 1'b0)
			report_mismatch("cdb_req", cdb_req, 0);
		if (cdb_out.valid !== 1'b0)
			report_mismatch("cdb_out.valid", cdb_out.valid, 0);
		if (credit_ret !== 1'b0)
			report_mismatch("credit_ret", credit_ret, 0);
	endtask

	// a request must belong to a load whose base has arrived
	task automatic verify_request();
		logic	hit;
		hit = 1'b0;
		for (int t = 0; t < NTAGS; t++)
			if (pend[t] && woke[t] && exp_waddr[t] == mem_req.waddr)
				hit = 1'b1;
		if (!hit)
			note_error($sformatf("memory request to word %h matches no ready load",
				mem_req.waddr));
	endtask

	task automatic score_result();
		lb_tag_t	t;
		t = cdb_out.tag;
		if (!pend[t])
			note_error($sformatf("result for rob tag %h, which is not outstanding", t));
		else
		begin
			if (cdb_out.data !== mem_word(exp_waddr[t]))
				report_mismatch("cdb_out.data", cdb_out.data, mem_word(exp_waddr[t]));
			pend[t] = 1'b0;
			done[t] = 1'b1;
			n_pend--;
			done_cnt++;
		end
	endtask

	task automatic kill_pending();
		for (int t = 0; t < NTAGS; t++)
			if (pend[t])
			begin
				pend[t] = 1'b0;
				killed[t] = 1'b1;
			end
		n_pend = 0;
		credits = `LB_DEPTH;	// entries cleared by flush come back at once
	endtask

	// scoreboard, sees the values from before the edge
	always @(posedge clk)
	begin
		if (arst_n && (!arst_q || flush_q))
			expect_quiet();
		if (arst_n)
		begin
			if (mem_req.valid)
				verify_request();
			if (stall_q && !cdb_req)
				note_error("cdb_req dropped without a grant");
			if (stall_q && cdb_req && cdb_out !== out_q)
				report_mismatch("cdb_out", cdb_out, out_q);	// back-pressure hold
			if (cdb_req && cdb_out.valid !== 1'b1)
				report_mismatch("cdb_out.valid", cdb_out.valid, 1);
			if (cdb_req && cdb_grant && !flush)
				score_result();
			if (credit_ret)
				ret_cnt++;
			if (flush)
				kill_pending();
			else
			begin
				if (issue.valid)
					credits--;
				if (credit_ret)
					credits++;
			end
		end
		stall_q = arst_n && cdb_req && !cdb_grant && !flush;
		out_q = cdb_out;
		arst_q = arst_n;
		flush_q = flush;
	end

	// memory model and cdb arbiter, all random draws in one process
	initial
	begin
		logic						mem_busy;
		int							mem_cnt;
		logic [`LB_WADDR_W-1:0]		mem_addr;
		int							gnt_wait;
		mem_busy = 1'b0;
		mem_cnt = 0;
		mem_addr = '0;
		gnt_wait = -1;
		forever
		begin
			@(negedge clk);
			mem_rsp = '0;
			if (mem_busy)
			begin
				mem_cnt--;
				if (mem_cnt == 0)
				begin
					mem_rsp = '{valid: 1'b1, data: mem_word(mem_addr)};
					mem_busy = 1'b0;
				end
			end
			if (arst_n && mem_req.valid)
			begin
				mem_busy = 1'b1;
				mem_addr = mem_req.waddr;
				mem_cnt = 1 + ($random(seed) & 3);
			end
			if (!cdb_req)
			begin
				cdb_grant = 1'b0;
				gnt_wait = -1;
			end
			else if (!cdb_grant)
			begin
				if (gnt_wait < 0)
					gnt_wait = $random(seed) & 3;	// 0 to 3 cycles of back-pressure
				if (gnt_wait == 0)
					cdb_grant = 1'b1;
				else
					gnt_wait--;
			end
		end
	end

	initial
	begin
		repeat (WDOG_CYCLES) @(posedge clk);
		$display("timeout: still running after %0d cycles with %0d loads outstanding",
			WDOG_CYCLES, n_pend);
		$display("errors %0d, loads completed %0d, credits returned %0d",
			errors + 1, done_cnt, ret_cnt);
		$display("TEST FAILED");
		$finish;
	end

	initial
	begin
		arst_n = 1'b0;
		flush = 1'b0;
		issue = '0;
		cdb_in = '0;
		mem_rsp = '0;
		cdb_grant = 1'b0;
		fill_table();
		for (int r = 0; r < NROWS; r++)
		begin
			issued[r] = 1'b0;
			fired[r] = 1'b0;
			wake_due[r] = 0;
		end
		for (int t = 0; t < NTAGS; t++)
		begin
			pend[t] = 1'b0;
			woke[t] = 1'b0;
			done[t] = 1'b0;
			killed[t] = 1'b0;
			exp_waddr[t] = '0;
		end
		repeat (5) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		for (int r = 0; r < NROWS; r++)
		begin
			if (rows[r].ctl == CTL_DRAIN)
				while (n_pend != 0)
					next_cycle();
			issue_row(r);
			if (rows[r].ctl == CTL_FLUSH)
			begin
				repeat (2) next_cycle();
				flush = 1'b1;
				next_cycle();
			end
		end
		while (n_pend != 0)
			next_cycle();
		repeat (3) next_cycle();	// last credit_ret trails its grant
		for (int r = 0; r < NROWS; r++)
			if (!done[rows[r].rob_tag] && !killed[rows[r].rob_tag])
				note_error($sformatf("no result for rob tag %h", rows[r].rob_tag));
		if (credits != `LB_DEPTH)
			report_mismatch("credit count", credits, `LB_DEPTH);
		if (ret_cnt != done_cnt)
			report_mismatch("credit_ret pulses", ret_cnt, done_cnt);
		$display("errors %0d, loads completed %0d, credits returned %0d",
			errors, done_cnt, ret_cnt);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
+incdir+include
rtl/lb_pkg.sv
rtl/lb_entries.sv
rtl/lb_agu.sv
rtl/lb_ctrl.sv
rtl/lb_result.sv
rtl/load_buffer.sv
sim/tb_load_buffer.sv

// File: Makefile
BIN := obj_dir/Vtb_load_buffer
SRCS := $(filter-out +%,$(shell cat sim.f)) include/lb_defs.svh

.PHONY: run clean

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'TEST PASSED'

$(BIN): sim.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f sim.f \
		--top-module tb_load_buffer -Mdir obj_dir

clean:
	rm -rf obj_dir
